/* rtl/mips_pkg.sv */
package mips_pkg;

    // basic machine words
    typedef logic [31:0] word_t;
    typedef logic [4:0] creg_addr_t;

    // per-byte write enable seen on the trace port
    typedef logic [3:0] rwen_t;

    // access size: 0 byte, 1 halfword, 2 word
    typedef logic [1:0] size_t;

    // one retire slot from the core
    typedef struct packed {
        logic       valid;
        logic       wen;
        creg_addr_t addr;
        word_t      wd;
    } rf_w_t;

    // virtual address, read either as a whole word or as segment plus offset
    typedef union packed {
        word_t raw;
        struct packed {
            logic [3:0]  seg;
            logic [27:0] offset;
        } f;
    } vaddr_t;

    // unmapped segments, the odd neighbour of each maps to the upper half
    localparam logic [3:0] SEG_KSEG0_LO = 4'h8;
    localparam logic [3:0] SEG_KSEG1_LO = 4'ha;

endpackage

/* rtl/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if;

    // request side, driven by the master
    logic              req;
    logic              wr;
    mips_pkg::size_t   size;
    mips_pkg::word_t   addr;
    mips_pkg::word_t   wdata;

    // response side, driven by the slave
    mips_pkg::word_t   rdata;
    logic              addr_ok;
    logic              data_ok;

    modport master (
        output req, wr, size, addr, wdata,
        input  rdata, addr_ok, data_ok
    );

    modport slave (
        input  req, wr, size, addr, wdata,
        output rdata, addr_ok, data_ok
    );

endinterface

/* rtl/vaddr_map.sv */
`timescale 1ns/1ps

module vaddr_map #(
    parameter logic DO_ADDR_TRANSLATION = 1'b1
) (
    input  mips_pkg::word_t vaddr,
    output mips_pkg::word_t paddr
);

    mips_pkg::vaddr_t va;
    mips_pkg::vaddr_t pa;

    assign va.raw = vaddr;

    if (DO_ADDR_TRANSLATION) begin : g_xlate
        always_comb begin
            pa = va;
            // kseg0/kseg1 strip the segment bits, offset is untouched
            case (va.f.seg)
                mips_pkg::SEG_KSEG0_LO,
                mips_pkg::SEG_KSEG1_LO: begin
                    pa.f.seg = 4'h0;
                end
                mips_pkg::SEG_KSEG0_LO + 4'd1,
                mips_pkg::SEG_KSEG1_LO + 4'd1: begin
                    pa.f.seg = 4'h1;
                end
                default: begin
                    pa.f.seg = va.f.seg;
                end
            endcase
        end
    end else begin : g_pass
        // no mapping, physical equals virtual
        assign pa = va;
    end

    assign paddr = pa.raw;

endmodule

/* rtl/sram_handshake.sv */
`timescale 1ns/1ps

module sram_handshake (
    input  logic clk,
    input  logic reset,
    input  logic cpu_req,
    input  logic addr_ok,
    input  logic data_ok,
    output logic req,
    output logic cpu_data_ok
);

    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_ADDR = 2'd1,
        S_WAIT = 2'd2
    } state_e;

    state_e state;
    state_e state_next;
    logic   req_next;

    always_comb begin
        state_next = state;
        req_next   = req;
        case (state)
            S_IDLE: begin
                // core holds den until completion
                if (cpu_req) begin
                    state_next = S_ADDR;
                    req_next   = 1'b1;
                end
            end
            S_ADDR: begin
                // slave samples the address in this cycle
                if (addr_ok) begin
                    state_next = S_WAIT;
                    req_next   = 1'b0;
                end
            end
            S_WAIT: begin
                if (data_ok) begin
                    state_next = S_IDLE;
                end
            end
            default: begin
                state_next = S_IDLE;
                req_next   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            req   <= 1'b0;
        end else begin
            state <= state_next;
            req   <= req_next;
        end
    end

    // completion lines up with data_ok from the slave
    assign cpu_data_ok = (state == S_WAIT) && data_ok;

endmodule

/* rtl/bus_adapter.sv */
`timescale 1ns/1ps

module bus_adapter #(
    parameter logic DO_ADDR_TRANSLATION = 1'b1
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            den,
    input  logic            dwt,
    input  mips_pkg::size_t dsize,
    input  mips_pkg::word_t daddr,
    input  mips_pkg::word_t dwd,
    input  mips_pkg::word_t iaddr,
    output logic            d_data_ok,
    output mips_pkg::word_t drd,
    output mips_pkg::word_t inst_addr,
    mem_bus_if.master       bus
);

    mips_pkg::word_t data_paddr;
    logic            bus_req;

    // data side address
    vaddr_map #(
        .DO_ADDR_TRANSLATION(DO_ADDR_TRANSLATION)
    ) d_map (
        .vaddr(daddr),
        .paddr(data_paddr)
    );

    // fetch address only gets translated here
    vaddr_map #(
        .DO_ADDR_TRANSLATION(DO_ADDR_TRANSLATION)
    ) i_map (
        .vaddr(iaddr),
        .paddr(inst_addr)
    );

    sram_handshake d_handshake (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (den),
        .addr_ok     (bus.addr_ok),
        .data_ok     (bus.data_ok),
        .req         (bus_req),
        .cpu_data_ok (d_data_ok)
    );

    // operands are held stable by the core, so they go straight out
    assign bus.req   = bus_req;
    assign bus.wr    = dwt;
    assign bus.size  = dsize;
    assign bus.addr  = data_paddr;
    assign bus.wdata = dwd;

    // only meaningful while d_data_ok is high
    assign drd = bus.rdata;

endmodule

/* rtl/rfwrite_queue.sv */
`timescale 1ns/1ps

module rfwrite_queue #(
    parameter int RETIRE_DEPTH = 8
) (
    input  logic                      clk,
    input  logic                      reset,
    input  mips_pkg::rf_w_t [1:0]     rfw_in,
    input  mips_pkg::word_t [1:0]     rt_pc_in,
    output mips_pkg::word_t           debug_wb_pc,
    output mips_pkg::rwen_t           debug_wb_rf_wen,
    output mips_pkg::creg_addr_t      debug_wb_rf_wnum,
    output mips_pkg::word_t           debug_wb_rf_wdata
);

    localparam int PTR_W = $clog2(RETIRE_DEPTH);
    localparam logic [PTR_W:0] PTR_ONE = 1;

    // entry storage
    mips_pkg::rf_w_t slot_mem [RETIRE_DEPTH];
    mips_pkg::word_t pc_mem   [RETIRE_DEPTH];

    // extra msb tells full from empty
    logic [PTR_W:0]   wr_ptr;
    logic [PTR_W:0]   rd_ptr;
    logic [PTR_W:0]   wr_next1;
    logic [PTR_W:0]   push_inc;
    logic [PTR_W:0]   occupancy;
    logic [PTR_W-1:0] wr_idx0;
    logic [PTR_W-1:0] wr_idx1;
    logic [PTR_W-1:0] rd_idx;
    logic             empty;
    mips_pkg::rf_w_t  head;

    assign occupancy = wr_ptr - rd_ptr;
    assign empty     = (occupancy == '0);

    assign wr_next1 = wr_ptr + PTR_ONE;
    assign wr_idx0  = wr_ptr[PTR_W-1:0];
    // slot 1 lands behind slot 0 only if slot 0 was taken
    assign wr_idx1  = rfw_in[0].valid ? wr_next1[PTR_W-1:0] : wr_idx0;
    assign rd_idx   = rd_ptr[PTR_W-1:0];
    assign head     = slot_mem[rd_idx];

    always_comb begin
        push_inc      = '0;
        push_inc[1:0] = {1'b0, rfw_in[0].valid} + {1'b0, rfw_in[1].valid};
    end

    always_ff @(posedge clk) begin
        if (rfw_in[0].valid) begin
            slot_mem[wr_idx0] <= rfw_in[0];
            pc_mem[wr_idx0]   <= rt_pc_in[0];
        end
        if (rfw_in[1].valid) begin
            slot_mem[wr_idx1] <= rfw_in[1];
            pc_mem[wr_idx1]   <= rt_pc_in[1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr + push_inc;
            // drain one entry per cycle
            if (!empty) begin
                rd_ptr <= rd_ptr + PTR_ONE;
            end
        end
    end

    // full write enable only for a real write to a nonzero register
    always_ff @(posedge clk) begin
        if (reset) begin
            debug_wb_rf_wen <= '0;
        end else if (!empty) begin
            debug_wb_rf_wen <= {4{head.wen && (head.addr != '0)}};
        end else begin
            debug_wb_rf_wen <= '0;
        end
    end

    // trace payload keeps its last value while idle
    always_ff @(posedge clk) begin
        if (!empty) begin
            debug_wb_pc       <= pc_mem[rd_idx];
            debug_wb_rf_wnum  <= head.addr;
            debug_wb_rf_wdata <= head.wd;
        end
    end

endmodule

/* rtl/mycpu_top.sv */
`timescale 1ns/1ps

module mycpu_top #(
    parameter logic DO_ADDR_TRANSLATION = 1'b1,
    parameter int   RETIRE_DEPTH        = 8
) (
    input  logic                      clk,
    input  logic                      reset,

    // core data request
    input  logic                      den,
    input  logic                      dwt,
    input  mips_pkg::size_t           dsize,
    input  mips_pkg::word_t           daddr,
    input  mips_pkg::word_t           dwd,
    input  mips_pkg::word_t           iaddr,

    // back to the core
    output logic                      d_data_ok,
    output mips_pkg::word_t           drd,
    output mips_pkg::word_t           inst_addr,

    // retire slots, slot 0 is older
    input  mips_pkg::rf_w_t [1:0]     rfw_in,
    input  mips_pkg::word_t [1:0]     rt_pc_in,

    // sram-like data bus
    output logic                      data_req,
    output logic                      data_wr,
    output mips_pkg::size_t           data_size,
    output mips_pkg::word_t           data_addr,
    output mips_pkg::word_t           data_wdata,
    input  mips_pkg::word_t           data_rdata,
    input  logic                      data_addr_ok,
    input  logic                      data_data_ok,

    // writeback trace
    output mips_pkg::word_t           debug_wb_pc,
    output mips_pkg::rwen_t           debug_wb_rf_wen,
    output mips_pkg::creg_addr_t      debug_wb_rf_wnum,
    output mips_pkg::word_t           debug_wb_rf_wdata
);

    mem_bus_if data_bus ();

    bus_adapter #(
        .DO_ADDR_TRANSLATION(DO_ADDR_TRANSLATION)
    ) bus_adapter_i (
        .clk       (clk),
        .reset     (reset),
        .den       (den),
        .dwt       (dwt),
        .dsize     (dsize),
        .daddr     (daddr),
        .dwd       (dwd),
        .iaddr     (iaddr),
        .d_data_ok (d_data_ok),
        .drd       (drd),
        .inst_addr (inst_addr),
        .bus       (data_bus)
    );

    // slave side of the bus goes out on plain ports
    assign data_req          = data_bus.req;
    assign data_wr           = data_bus.wr;
    assign data_size         = data_bus.size;
    assign data_addr         = data_bus.addr;
    assign data_wdata        = data_bus.wdata;
    assign data_bus.rdata    = data_rdata;
    assign data_bus.addr_ok  = data_addr_ok;
    assign data_bus.data_ok  = data_data_ok;

    rfwrite_queue #(
        .RETIRE_DEPTH(RETIRE_DEPTH)
    ) rfwrite_queue_i (
        .clk               (clk),
        .reset             (reset),
        .rfw_in            (rfw_in),
        .rt_pc_in          (rt_pc_in),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

/* tb/mycpu_sva.sv */
`timescale 1ns/1ps

module mycpu_sva #(
    parameter bit QUEUE_SIDE   = 1'b0,
    parameter int OCC_W        = 1,
    parameter int RETIRE_DEPTH = 1
) (
    input logic             clk,
    input logic             reset,
    input logic             req,
    input logic             addr_ok,
    input logic             cpu_data_ok,
    input logic [OCC_W-1:0] occupancy
);

    if (!QUEUE_SIDE) begin : g_handshake
        // set by an address acceptance and cleared by its completion
        logic accepted;

        always_ff @(posedge clk) begin
            if (reset) begin
                accepted <= 1'b0;
            end else if (req && addr_ok) begin
                accepted <= 1'b1;
            end else if (cpu_data_ok) begin
                accepted <= 1'b0;
            end
        end

        req_held: assert property (@(posedge clk) disable iff (reset)
            req && !addr_ok |=> req)
            else $error("req dropped before addr_ok");

        done_after_accept: assert property (@(posedge clk) disable iff (reset)
            cpu_data_ok |-> accepted)
            else $error("cpu_data_ok without a preceding address acceptance");
    end else begin : g_queue
        queue_bound: assert property (@(posedge clk) disable iff (reset)
            int'(occupancy) <= RETIRE_DEPTH)
            else $error("retire queue holds more entries than its depth");
    end

endmodule

bind sram_handshake mycpu_sva handshake_sva (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .addr_ok     (addr_ok),
    .cpu_data_ok (cpu_data_ok),
    .occupancy   (1'b0)
);

bind rfwrite_queue mycpu_sva #(
    .QUEUE_SIDE   (1'b1),
    .OCC_W        ($clog2(RETIRE_DEPTH) + 1),
    .RETIRE_DEPTH (RETIRE_DEPTH)
) queue_sva (
    .clk         (clk),
    .reset       (reset),
    .req         (1'b0),
    .addr_ok     (1'b0),
    .cpu_data_ok (1'b0),
    .occupancy   (occupancy)
);

/* tb/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    localparam int RETIRE_DEPTH = 8;
    localparam int WAIT_LIMIT   = 40;
    // register writes in the table that reach the trace
    localparam int EXP_WRITES   = 12;

    // one operation with its addresses, data and retire pair
    typedef struct packed {
        logic                  st;
        mips_pkg::word_t       va;
        mips_pkg::word_t       wd;
        mips_pkg::word_t       pa;
        mips_pkg::rf_w_t [1:0] slots;
    } row_t;

    typedef struct packed {
        mips_pkg::word_t      pc;
        mips_pkg::creg_addr_t num;
        mips_pkg::word_t      data;
    } trace_t;

    logic clk;
    logic reset;
    logic den;
    logic dwt;
    logic d_data_ok;
    logic data_req;
    logic data_wr;
    logic data_addr_ok;
    logic data_data_ok;
    mips_pkg::size_t       dsize;
    mips_pkg::size_t       data_size;
    mips_pkg::word_t       daddr;
    mips_pkg::word_t       dwd;
    mips_pkg::word_t       iaddr;
    mips_pkg::word_t       drd;
    mips_pkg::word_t       inst_addr;
    mips_pkg::word_t       data_addr;
    mips_pkg::word_t       data_wdata;
    mips_pkg::word_t       data_rdata;
    mips_pkg::rf_w_t [1:0] rfw_in;
    mips_pkg::word_t [1:0] rt_pc_in;
    mips_pkg::word_t       debug_wb_pc;
    mips_pkg::rwen_t       debug_wb_rf_wen;
    mips_pkg::creg_addr_t  debug_wb_rf_wnum;
    mips_pkg::word_t       debug_wb_rf_wdata;

    row_t            rows[$];
    trace_t          exp_trace[$];
    trace_t          mon_exp;
    mips_pkg::word_t mem[mips_pkg::word_t];
    mips_pkg::word_t exp_mem[mips_pkg::word_t];
    int              acc_count = 0;
    int              done_count = 0;
    int              trace_count = 0;
    int              waited;
    logic            acc_wr;
    mips_pkg::size_t acc_size;
    mips_pkg::word_t acc_addr;
    mips_pkg::word_t acc_wdata;
    mips_pkg::word_t done_rdata;

    mycpu_top #(
        .DO_ADDR_TRANSLATION(1'b1),
        .RETIRE_DEPTH(RETIRE_DEPTH)
    ) mycpu_top_i (.*);

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    // segments 8 to 11 keep only their low segment bit
    function automatic mips_pkg::word_t seg_map(input mips_pkg::word_t v);
        if (v[31:28] >= mips_pkg::SEG_KSEG0_LO && v[31:28] <= mips_pkg::SEG_KSEG1_LO + 4'd1) begin
            return {3'b000, v[28], v[27:0]};
        end
        return v;
    endfunction

    // content of a word never written
    function automatic mips_pkg::word_t fill_word(input mips_pkg::word_t a);
        return {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;
    endfunction

    task automatic add_row(input logic st, input mips_pkg::word_t va, input mips_pkg::word_t wd,
                           input mips_pkg::word_t pa, input mips_pkg::rf_w_t s0,
                           input mips_pkg::rf_w_t s1);
        row_t r;
        r.st       = st;
        r.va       = va;
        r.wd       = wd;
        r.pa       = pa;
        r.slots[0] = s0;
        r.slots[1] = s1;
        rows.push_back(r);
    endtask

    // slots are {valid, wen, register, data}
    task automatic build_table();
        add_row(1'b1, 32'h8000_0100, 32'h1111_aaaa, 32'h0000_0100,
                {1'b1, 1'b1, 5'd3, 32'h0103_0003}, {1'b1, 1'b1, 5'd4, 32'h0104_0004});
        add_row(1'b0, 32'h8000_0100, 32'h0, 32'h0000_0100,
                {1'b1, 1'b1, 5'd0, 32'hdead_0000}, {1'b1, 1'b0, 5'd7, 32'h0207_0007});
        add_row(1'b1, 32'h9fc0_0200, 32'h2222_bbbb, 32'h1fc0_0200,
                {1'b0, 1'b1, 5'd5, 32'h0305_0005}, {1'b1, 1'b1, 5'd9, 32'h0309_0009});
        add_row(1'b0, 32'ha000_0100, 32'h0, 32'h0000_0100,
                {1'b1, 1'b1, 5'd10, 32'h040a_000a}, {1'b0, 1'b0, 5'd0, 32'h0});
        add_row(1'b1, 32'hb000_0300, 32'h3333_cccc, 32'h1000_0300,
                {1'b1, 1'b1, 5'd31, 32'h051f_001f}, {1'b1, 1'b1, 5'd1, 32'h0501_0001});
        add_row(1'b0, 32'h9000_0300, 32'h0, 32'h1000_0300,
                {1'b0, 1'b0, 5'd0, 32'h0}, {1'b0, 1'b0, 5'd0, 32'h0});
        add_row(1'b1, 32'h0040_0010, 32'h4444_dddd, 32'h0040_0010,
                {1'b1, 1'b1, 5'd2, 32'h0702_0020}, {1'b1, 1'b1, 5'd2, 32'h0702_0021});
        add_row(1'b0, 32'h0040_0010, 32'h0, 32'h0040_0010,
                {1'b1, 1'b0, 5'd0, 32'h0800_0000}, {1'b1, 1'b1, 5'd12, 32'h080c_000c});
        add_row(1'b0, 32'h9fc0_0200, 32'h0, 32'h1fc0_0200,
                {1'b1, 1'b1, 5'd13, 32'h090d_000d}, {1'b1, 1'b1, 5'd14, 32'h090e_000e});
        add_row(1'b0, 32'hc000_0040, 32'h0, 32'hc000_0040,
                {1'b1, 1'b1, 5'd15, 32'h0a0f_000f}, {1'b1, 1'b1, 5'd0, 32'h0a00_0000});
    endtask

    // only valid slots with a real register write reach the trace
    task automatic expect_slot(input mips_pkg::rf_w_t s, input mips_pkg::word_t pc);
        trace_t t;
        if (s.valid && s.wen && s.addr != 5'd0) begin
            t.pc   = pc;
            t.num  = s.addr;
            t.data = s.wd;
            exp_trace.push_back(t);
        end
    endtask

    task automatic run_row(input int idx);
        row_t            r;
        int              acc_before;
        int              done_before;
        int              cycles;
        logic            got;
        mips_pkg::word_t exp_rd;
        r      = rows[idx];
        exp_rd = exp_mem.exists(r.pa) ? exp_mem[r.pa] : fill_word(r.pa);
        if (r.st) begin
            exp_mem[r.pa] = r.wd;
        end
        @(posedge clk);
        #1;
        acc_before  = acc_count;
        done_before = done_count;
        den         = 1'b1;
        dwt         = r.st;
        dsize       = 2'd2;
        daddr       = r.va;
        dwd         = r.wd;
        iaddr       = {r.va[31:28], ~r.va[27:0]};
        rfw_in      = r.slots;
        rt_pc_in[0] = 32'hbfc0_0000 + 32'(idx) * 32'd8;
        rt_pc_in[1] = rt_pc_in[0] + 32'd4;
        expect_slot(r.slots[0], rt_pc_in[0]);
        expect_slot(r.slots[1], rt_pc_in[1]);
        @(negedge clk);
        assert (inst_addr == seg_map(iaddr)) else fail_now($sformatf(
            "MISMATCH inst_addr got %08h expected %08h", inst_addr, seg_map(iaddr)));
        @(posedge clk);
        #1;
        rfw_in = '0;
        got    = 1'b0;
        cycles = 0;
        while (!got && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            got = d_data_ok;
            cycles++;
        end
        if (!got) begin
            fail_now("timeout waiting for d_data_ok");
        end
        // monitor has counted the completion cycle at this edge
        @(posedge clk);
        #1;
        den = 1'b0;
        assert (acc_count == acc_before + 1) else fail_now($sformatf(
            "MISMATCH data_addr_ok acceptances got %0h expected %0h",
            acc_count - acc_before, 1));
        assert (done_count == done_before + 1) else fail_now($sformatf(
            "MISMATCH d_data_ok got %0h expected %0h", done_count - done_before, 1));
        assert (acc_addr == r.pa) else fail_now($sformatf(
            "MISMATCH data_addr got %08h expected %08h", acc_addr, r.pa));
        assert (acc_wr == r.st) else fail_now($sformatf(
            "MISMATCH data_wr got %0h expected %0h", acc_wr, r.st));
        assert (acc_size == 2'd2) else fail_now($sformatf(
            "MISMATCH data_size got %0h expected %0h", acc_size, 2'd2));
        if (r.st) begin
            assert (acc_wdata == r.wd) else fail_now($sformatf(
                "MISMATCH data_wdata got %08h expected %08h", acc_wdata, r.wd));
        end else begin
            assert (done_rdata == exp_rd) else fail_now($sformatf(
                "MISMATCH drd got %08h expected %08h", done_rdata, exp_rd));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // sram slave with random address and data delays
    initial begin : sram_slave
        int              delay;
        logic            w;
        mips_pkg::word_t a;
        data_addr_ok = 1'b0;
        data_data_ok = 1'b0;
        data_rdata   = '0;
        forever begin
            @(posedge clk);
            #1;
            if (data_req && !reset) begin
                delay = $urandom % 4;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                data_addr_ok = 1'b1;
                a = data_addr;
                w = data_wr;
                if (w) begin
                    mem[a] = data_wdata;
                end
                @(posedge clk);
                #1;
                data_addr_ok = 1'b0;
                delay = $urandom % 4;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                data_rdata   = mem.exists(a) ? mem[a] : fill_word(a);
                data_data_ok = 1'b1;
                @(posedge clk);
                #1;
                data_data_ok = 1'b0;
            end
        end
    end

    // bus and trace monitor
    always @(posedge clk) begin
        if (!reset) begin
            if (data_req && data_addr_ok) begin
                acc_count++;
                acc_addr  = data_addr;
                acc_wr    = data_wr;
                acc_size  = data_size;
                acc_wdata = data_wdata;
            end
            if (d_data_ok) begin
                done_count++;
                done_rdata = drd;
            end
            if (debug_wb_rf_wen != 4'h0) begin
                assert (exp_trace.size() != 0)
                    else fail_now("writeback trace entry appeared with none expected");
                mon_exp = exp_trace.pop_front();
                assert (debug_wb_rf_wen == 4'hf) else fail_now($sformatf(
                    "MISMATCH debug_wb_rf_wen got %0h expected %0h", debug_wb_rf_wen, 4'hf));
                assert (debug_wb_pc == mon_exp.pc) else fail_now($sformatf(
                    "MISMATCH debug_wb_pc got %08h expected %08h", debug_wb_pc, mon_exp.pc));
                assert (debug_wb_rf_wnum == mon_exp.num) else fail_now($sformatf(
                    "MISMATCH debug_wb_rf_wnum got %0h expected %0h",
                    debug_wb_rf_wnum, mon_exp.num));
                assert (debug_wb_rf_wdata == mon_exp.data) else fail_now($sformatf(
                    "MISMATCH debug_wb_rf_wdata got %08h expected %08h",
                    debug_wb_rf_wdata, mon_exp.data));
                trace_count++;
            end
        end
    end

    initial begin
        void'($urandom(47095));
        reset    = 1'b1;
        den      = 1'b0;
        dwt      = 1'b0;
        dsize    = '0;
        daddr    = '0;
        dwd      = '0;
        iaddr    = '0;
        rfw_in   = '0;
        rt_pc_in = '0;
        build_table();
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        assert (data_req == 1'b0) else fail_now($sformatf(
            "MISMATCH data_req got %0h expected %0h", data_req, 1'b0));
        assert (d_data_ok == 1'b0) else fail_now($sformatf(
            "MISMATCH d_data_ok got %0h expected %0h", d_data_ok, 1'b0));
        assert (debug_wb_rf_wen == 4'h0) else fail_now($sformatf(
            "MISMATCH debug_wb_rf_wen got %0h expected %0h", debug_wb_rf_wen, 4'h0));
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        waited = 0;
        while (exp_trace.size() != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_trace.size() != 0) begin
            fail_now("timeout waiting for the writeback trace to drain");
        end
        // a few idle cycles so a stray trace entry would show up
        repeat (4) @(posedge clk);
        #1;
        if (trace_count == EXP_WRITES) begin
            $display(">>> PASS");
            $finish;
        end else begin
            fail_now($sformatf("MISMATCH trace_count got %0h expected %0h",
                trace_count, EXP_WRITES));
        end
    end

endmodule

/* sim.f */
rtl/mips_pkg.sv
rtl/mem_bus_if.sv
rtl/vaddr_map.sv
rtl/sram_handshake.sv
rtl/bus_adapter.sv
rtl/rfwrite_queue.sv
rtl/mycpu_top.sv
tb/mycpu_sva.sv
tb/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_top -f sim.f -o tb_top_sim

sim_out=$(./obj_dir/tb_top_sim 2>&1 || true)
echo "${sim_out}"

if grep -qx '>>> PASS' <<< "${sim_out}"; then
    exit 0
else
    exit 1
fi
